//--- logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;
	typedef logic [11:0] imm_short_t;
	typedef logic [11:0] csr_addr_t;

	// base opcodes
	localparam opcode_t OP     = 7'b0110011;
	localparam opcode_t OP_IMM = 7'b0010011;
	localparam opcode_t LOAD   = 7'b0000011;
	localparam opcode_t STORE  = 7'b0100011;
	localparam opcode_t BRANCH = 7'b1100011;
	localparam opcode_t JAL    = 7'b1101111;
	localparam opcode_t JALR   = 7'b1100111;
	localparam opcode_t LUI    = 7'b0110111;
	localparam opcode_t AUIPC  = 7'b0010111;
	localparam opcode_t SYSTEM = 7'b1110011;

	// lsb of each field in the instruction word
	localparam int OPCODE_LSB = 0;
	localparam int RD_LSB     = 7;
	localparam int FUNCT3_LSB = 12;
	localparam int RS1_LSB    = 15;
	localparam int RS2_LSB    = 20;
	localparam int FUNCT7_LSB = 25;

	// user counters, read only
	localparam csr_addr_t CSR_CYCLE    = 12'hC00;
	localparam csr_addr_t CSR_INSTRET  = 12'hC02;
	localparam csr_addr_t CSR_CYCLEH   = 12'hC80;
	localparam csr_addr_t CSR_INSTRETH = 12'hC82;

endpackage

`default_nettype wire

//--- logic/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_REG,
		ALU_IMM,
		ALU_BRANCH,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_MEM,
		S_WB
	} core_state_t;

endpackage

`default_nettype wire

//--- logic/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rv_isa_pkg::*, core_ctrl_pkg::*; (
	input wire word_t instruction,
	output opcode_t opcode,
	output funct3_t func3,
	output funct7_t func7,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output reg_addr_t rd,
	output logic write_reg,
	output logic alu_src,
	output logic mem_to_reg,
	output logic read_mem,
	output logic write_mem,
	output logic imm_shift,
	output logic imm_src,
	output logic branch,
	output logic jalr,
	output logic auipc,
	output logic csr_type,
	output alu_op_t alu_op,
	output imm_short_t imm_short,
	output word_t imm_long
);

	assign opcode = instruction[OPCODE_LSB +: 7];
	assign rd     = instruction[RD_LSB +: 5];
	assign func3  = instruction[FUNCT3_LSB +: 3];
	assign rs1    = instruction[RS1_LSB +: 5];
	assign rs2    = instruction[RS2_LSB +: 5];
	assign func7  = instruction[FUNCT7_LSB +: 7];

	always_comb begin
		// everything low is a no-op
		write_reg = 1'b0;
		alu_src = 1'b0;
		mem_to_reg = 1'b0;
		read_mem = 1'b0;
		write_mem = 1'b0;
		imm_shift = 1'b0;
		imm_src = 1'b0;
		branch = 1'b0;
		jalr = 1'b0;
		auipc = 1'b0;
		csr_type = 1'b0;
		alu_op = ALU_ADD;
		// i-type layout unless overridden
		imm_short = instruction[31:20];
		imm_long = '0;
		case (opcode)
			OP: begin
				write_reg = 1'b1;
				alu_op = ALU_REG;
			end
			OP_IMM: begin
				write_reg = 1'b1;
				alu_src = 1'b1;
				alu_op = ALU_IMM;
			end
			LOAD: begin
				write_reg = 1'b1;
				alu_src = 1'b1;
				mem_to_reg = 1'b1;
				read_mem = 1'b1;
			end
			STORE: begin
				alu_src = 1'b1;
				write_mem = 1'b1;
				imm_short = {instruction[31:25], instruction[11:7]};
			end
			BRANCH: begin
				branch = 1'b1;
				imm_shift = 1'b1;
				alu_op = ALU_BRANCH;
				// imm[12:1], bit 0 added by the shift
				imm_short = {instruction[31], instruction[7], instruction[30:25],
					instruction[11:8]};
			end
			JAL: begin
				write_reg = 1'b1;
				branch = 1'b1;
				imm_src = 1'b1;
				imm_shift = 1'b1;
				alu_op = ALU_PASS_B;
				// imm[20:1] kept unshifted in the low bits
				imm_long = {12'd0, instruction[31], instruction[19:12], instruction[20],
					instruction[30:21]};
			end
			JALR: begin
				write_reg = 1'b1;
				alu_src = 1'b1;
				jalr = 1'b1;
			end
			LUI: begin
				write_reg = 1'b1;
				alu_src = 1'b1;
				imm_src = 1'b1;
				alu_op = ALU_PASS_B;
				imm_long = {instruction[31:12], 12'd0};
			end
			AUIPC: begin
				write_reg = 1'b1;
				imm_src = 1'b1;
				auipc = 1'b1;
				imm_long = {instruction[31:12], 12'd0};
			end
			SYSTEM: begin
				// csrrs only
				if (func3 == 3'b010) begin
					write_reg = 1'b1;
					csr_type = 1'b1;
					alu_op = ALU_PASS_B;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import rv_isa_pkg::*, core_ctrl_pkg::*; (
	input wire alu_op_t alu_op,
	input wire funct3_t func3,
	input wire funct7_t func7,
	input wire word_t a,
	input wire word_t b,
	output word_t result,
	output logic cond
);

	logic alt;
	word_t sra_res;

	// sub for register ops, sra for both
	assign alt = func7[5] && (alu_op == ALU_REG || (alu_op == ALU_IMM && func3 == 3'b101));
	assign sra_res = $signed(a) >>> b[4:0];

	always_comb begin
		result = '0;
		// jumps are unconditional
		cond = 1'b1;
		case (alu_op)
			ALU_ADD: result = a + b;
			ALU_PASS_B: result = b;
			ALU_BRANCH: begin
				case (func3)
					3'b000: cond = (a == b);
					3'b001: cond = (a != b);
					3'b100: cond = ($signed(a) < $signed(b));
					3'b101: cond = ($signed(a) >= $signed(b));
					3'b110: cond = (a < b);
					3'b111: cond = (a >= b);
					default: cond = 1'b0;
				endcase
			end
			default: begin
				case (func3)
					3'b000: result = alt ? a - b : a + b;
					3'b001: result = a << b[4:0];
					3'b010: result = {31'd0, $signed(a) < $signed(b)};
					3'b011: result = {31'd0, a < b};
					3'b100: result = a ^ b;
					3'b101: result = alt ? sra_res : a >> b[4:0];
					3'b110: result = a | b;
					default: result = a & b;
				endcase
			end
		endcase
	end

	always_comb begin
		assert ($isunknown({alu_op, func3, func7}) || alu_op == ALU_BRANCH
			|| !$isunknown(result));
	end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_isa_pkg::*; (
	input wire clk,
	input wire rst,
	input wire reg_addr_t rs1,
	input wire reg_addr_t rs2,
	output word_t rs1_data,
	output word_t rs2_data,
	input wire we,
	input wire reg_addr_t rd,
	input wire word_t rd_data
);

	word_t regs [32];

	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			// x0 never written
			regs[rd] <= rd_data;
		end
	end

endmodule

`default_nettype wire

//--- logic/core_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module core_sequencer import rv_isa_pkg::*, core_ctrl_pkg::*; #(
	parameter word_t RESET_PC = '0
) (
	input wire clk,
	input wire rst,
	input wire read_mem,
	input wire write_mem,
	input wire branch,
	input wire jalr,
	input wire cond,
	input wire word_t target,
	input wire word_t jalr_target,
	output core_state_t state,
	output word_t pc,
	output logic retire
);

	core_state_t state_next;
	word_t pc_next;

	always_comb begin
		case (state)
			S_FETCH: state_next = S_DECODE;
			S_DECODE: state_next = S_EXEC;
			// only lw and sw visit memory
			S_EXEC: state_next = (read_mem || write_mem) ? S_MEM : S_WB;
			S_MEM: state_next = S_WB;
			default: state_next = S_FETCH;
		endcase
	end

	always_comb begin
		if (jalr) begin
			pc_next = jalr_target;
		end else if (branch && cond) begin
			pc_next = target;
		end else begin
			pc_next = pc + 32'd4;
		end
	end

	assign retire = (state == S_WB);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_FETCH;
			pc <= RESET_PC;
		end else begin
			state <= state_next;
			if (retire) begin
				pc <= pc_next;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) retire |=> !retire);

endmodule

`default_nettype wire

//--- logic/cycle_counter.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_counter import rv_isa_pkg::*; #(
	parameter int COUNTER_WIDTH = 64
) (
	input wire clk,
	input wire rst,
	input wire retire,
	input wire csr_addr_t csr_addr,
	output word_t csr_rdata
);

	logic [COUNTER_WIDTH-1:0] cycle_cnt;
	logic [COUNTER_WIDTH-1:0] instret_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cycle_cnt <= '0;
			instret_cnt <= '0;
		end else begin
			cycle_cnt <= cycle_cnt + 1'b1;
			if (retire) begin
				instret_cnt <= instret_cnt + 1'b1;
			end
		end
	end

	// upper halves shift out to zero on 32-bit counters
	always_comb begin
		case (csr_addr)
			CSR_CYCLE: csr_rdata = cycle_cnt[31:0];
			CSR_INSTRET: csr_rdata = instret_cnt[31:0];
			CSR_CYCLEH: csr_rdata = word_t'(cycle_cnt >> 32);
			CSR_INSTRETH: csr_rdata = word_t'(instret_cnt >> 32);
			default: csr_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_isa_pkg::*, core_ctrl_pkg::*; #(
	parameter word_t RESET_PC = '0,
	parameter int COUNTER_WIDTH = 64
) (
	input wire clk,
	input wire rst,
	output word_t imem_addr,
	input wire word_t imem_rdata,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic dmem_we,
	output logic dmem_re,
	input wire word_t dmem_rdata
);

	word_t ir;
	word_t rs1_q;
	word_t rs2_q;
	word_t result_q;
	word_t load_q;
	word_t rs1_data;
	word_t rs2_data;
	word_t imm;
	word_t alu_b;
	word_t alu_result;
	word_t target;
	word_t exec_value;
	word_t wb_data;
	word_t csr_rdata;
	word_t pc;
	word_t imm_long;
	opcode_t opcode;
	funct3_t func3;
	funct7_t func7;
	reg_addr_t rs1;
	reg_addr_t rs2;
	reg_addr_t rd;
	imm_short_t imm_short;
	alu_op_t alu_op;
	core_state_t state;
	logic write_reg;
	logic alu_src;
	logic mem_to_reg;
	logic read_mem;
	logic write_mem;
	logic imm_shift;
	logic imm_src;
	logic branch;
	logic jalr;
	logic auipc;
	logic csr_type;
	logic cond;
	logic retire;

	instr_decoder instr_decoder_i (
		.instruction(ir),
		.opcode(opcode),
		.func3(func3),
		.func7(func7),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.write_reg(write_reg),
		.alu_src(alu_src),
		.mem_to_reg(mem_to_reg),
		.read_mem(read_mem),
		.write_mem(write_mem),
		.imm_shift(imm_shift),
		.imm_src(imm_src),
		.branch(branch),
		.jalr(jalr),
		.auipc(auipc),
		.csr_type(csr_type),
		.alu_op(alu_op),
		.imm_short(imm_short),
		.imm_long(imm_long)
	);

	// sign extend, b and j offsets get bit 0 appended
	always_comb begin
		case ({imm_src, imm_shift})
			2'b00: imm = {{20{imm_short[11]}}, imm_short};
			2'b01: imm = {{19{imm_short[11]}}, imm_short, 1'b0};
			2'b10: imm = imm_long;
			default: imm = {{11{imm_long[19]}}, imm_long[19:0], 1'b0};
		endcase
	end

	assign alu_b = alu_src ? imm : rs2_q;
	assign target = pc + imm;

	alu alu_i (
		.alu_op(alu_op),
		.func3(func3),
		.func7(func7),
		.a(rs1_q),
		.b(alu_b),
		.result(alu_result),
		.cond(cond)
	);

	reg_file reg_file_i (
		.clk(clk),
		.rst(rst),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.we(write_reg && retire),
		.rd(rd),
		.rd_data(wb_data)
	);

	core_sequencer #(
		.RESET_PC(RESET_PC)
	) core_sequencer_i (
		.clk(clk),
		.rst(rst),
		.read_mem(read_mem),
		.write_mem(write_mem),
		.branch(branch),
		.jalr(jalr),
		.cond(cond),
		.target(target),
		.jalr_target({alu_result[31:1], 1'b0}),
		.state(state),
		.pc(pc),
		.retire(retire)
	);

	cycle_counter #(
		.COUNTER_WIDTH(COUNTER_WIDTH)
	) cycle_counter_i (
		.clk(clk),
		.rst(rst),
		.retire(retire),
		.csr_addr(csr_addr_t'(imm_short)),
		.csr_rdata(csr_rdata)
	);

	// link address for jal and jalr
	always_comb begin
		if (csr_type) begin
			exec_value = csr_rdata;
		end else if (auipc) begin
			exec_value = target;
		end else if (branch || jalr) begin
			exec_value = pc + 32'd4;
		end else begin
			exec_value = alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ir <= '0;
		end else if (state == S_FETCH) begin
			ir <= imem_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rs1_q <= '0;
			rs2_q <= '0;
		end else if (state == S_DECODE) begin
			rs1_q <= rs1_data;
			rs2_q <= rs2_data;
		end
		if (state == S_EXEC) begin
			result_q <= exec_value;
		end
		if (state == S_MEM) begin
			load_q <= dmem_rdata;
		end
	end

	assign wb_data = mem_to_reg ? load_q : result_q;

	assign imem_addr = pc;
	assign dmem_addr = result_q;
	assign dmem_wdata = rs2_q;
	assign dmem_we = write_mem && (state == S_MEM);
	assign dmem_re = read_mem && (state == S_MEM);

	// non-memory opcodes go straight to writeback
	assert property (@(posedge clk) disable iff (rst)
		(state == S_EXEC && opcode != LOAD && opcode != STORE) |=> state == S_WB);

endmodule

`default_nettype wire

//--- dv/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_isa_pkg::*; ();

	localparam word_t RESET_PC = 32'h0;
	localparam int TDATA_WORDS = 256;
	localparam int PAIR_BASE = 64;
	localparam int DMEM_WORDS = 256;

	logic clk;
	logic rst;
	word_t imem_addr;
	word_t imem_rdata;
	word_t dmem_addr;
	word_t dmem_wdata;
	word_t dmem_rdata;
	logic dmem_we;
	logic dmem_re;

	word_t tdata [TDATA_WORDS];
	word_t dmem [DMEM_WORDS];
	int num_pairs;
	int store_idx = 0;
	int errors = 0;
	int held = 0;
	word_t last_pc;
	bit loaded;
	bit after_reset = 1'b0;
	bit spacing_started = 1'b0;

	rv_core #(
		.RESET_PC(RESET_PC),
		.COUNTER_WIDTH(64)
	) rv_core_i (
		.clk(clk),
		.rst(rst),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.dmem_re(dmem_re),
		.dmem_rdata(dmem_rdata)
	);

	always #5 clk = ~clk;

	// program sits in the first 64 test data entries
	assign imem_rdata = tdata[{2'b00, imem_addr[7:2]}];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	always @(posedge clk) begin
		if (dmem_we) begin
			dmem[dmem_addr[9:2]] <= dmem_wdata;
		end
	end

	task automatic end_run(input bit failed);
		$display("run ended with %0d errors, %0d of %0d stores seen", errors, store_idx,
			num_pairs);
		if (failed || errors != 0) begin
			$display("Errors found");
		end else begin
			$display("No errors");
		end
		$finish;
	endtask

	task automatic check_idle();
		if (imem_addr !== RESET_PC) begin
			$display("[ERROR] imem_addr got %h expected %h", imem_addr, RESET_PC);
			errors++;
		end
		if (dmem_we !== 1'b0) begin
			$display("[ERROR] dmem_we got %h expected %h", dmem_we, 1'b0);
			errors++;
		end
		if (dmem_re !== 1'b0) begin
			$display("[ERROR] dmem_re got %h expected %h", dmem_re, 1'b0);
			errors++;
		end
	endtask

	// lw and sw take the extra memory cycle
	task automatic track_spacing();
		word_t last_word;
		int expected;
		if (!spacing_started) begin
			spacing_started = 1'b1;
			last_pc = imem_addr;
			held = 1;
		end else if (imem_addr === last_pc) begin
			held++;
		end else begin
			last_word = tdata[{2'b00, last_pc[7:2]}];
			expected = (last_word[6:0] == LOAD || last_word[6:0] == STORE) ? 5 : 4;
			if (held != expected) begin
				$display("instruction at pc %h lasted %0d cycles instead of %0d",
					last_pc, held, expected);
				errors++;
			end
			last_pc = imem_addr;
			held = 1;
		end
	endtask

	// read strobe only in the fourth cycle of a lw
	task automatic check_read_strobe();
		word_t cur_word;
		logic exp_re;
		cur_word = tdata[{2'b00, imem_addr[7:2]}];
		exp_re = (cur_word[6:0] == LOAD && held == 4);
		if (dmem_re !== exp_re) begin
			$display("[ERROR] dmem_re at pc %h got %h expected %h", imem_addr, dmem_re,
				exp_re);
			errors++;
		end
	endtask

	task automatic check_store();
		word_t exp_addr;
		word_t exp_data;
		if (store_idx >= num_pairs) begin
			$display("extra store number %0d to address %h that the program should not make",
				store_idx, dmem_addr);
			errors++;
		end else begin
			exp_addr = tdata[8'(PAIR_BASE + 2 * store_idx)];
			exp_data = tdata[8'(PAIR_BASE + 2 * store_idx + 1)];
			if (dmem_addr !== exp_addr) begin
				$display("[ERROR] dmem_addr store %0d got %h expected %h", store_idx,
					dmem_addr, exp_addr);
				errors++;
			end
			if (dmem_wdata !== exp_data) begin
				$display("[ERROR] dmem_wdata store %0d got %h expected %h", store_idx,
					dmem_wdata, exp_data);
				errors++;
			end
		end
		store_idx++;
	endtask

	// mid-cycle sampling, all outputs settled
	always @(negedge clk) begin
		if (rst || !after_reset) begin
			check_idle();
		end
		if (!rst) begin
			after_reset = 1'b1;
			track_spacing();
			check_read_strobe();
			if (dmem_we) begin
				check_store();
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		num_pairs = 0;
		loaded = 1'b0;
		for (int i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] = {24'hd00d00, 8'(i)};
		end
		$readmemh("dv/rv_core_testdata.hex", tdata);
		while (PAIR_BASE + 2 * num_pairs < TDATA_WORDS
			&& tdata[8'(PAIR_BASE + 2 * num_pairs)] !== 32'hFFFF_FFFF) begin
			num_pairs++;
		end
		loaded = 1'b1;
		if (PAIR_BASE + 2 * num_pairs >= TDATA_WORDS) begin
			$display("test data has no end marker after the expected stores");
			end_run(1'b1);
		end else begin
			repeat (10) @(posedge clk);
			#1;
			rst = 1'b0;
			wait (store_idx >= num_pairs);
			// program parks in a jump to itself, so a stray store shows up here
			repeat (20) @(posedge clk);
			end_run(1'b0);
		end
	end

	initial begin
		wait (loaded);
		repeat ((num_pairs + 64) * 5 * 10) @(posedge clk);
		$display("watchdog expired before all %0d expected stores were seen", num_pairs);
		end_run(1'b1);
	end

endmodule

`default_nettype wire

//--- build.f
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/core_sequencer.sv
logic/cycle_counter.sv
logic/rv_core.sv
dv/rv_core_tb.sv

//--- Makefile
SRCS := $(shell cat build.f)

obj_dir/Vrv_core_tb: build.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f build.f --top-module rv_core_tb

run: obj_dir/Vrv_core_tb dv/rv_core_testdata.hex
	./obj_dir/Vrv_core_tb | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- dv/rv_core_testdata.hex
// entries 0-63: program words, one per line, pc and assembly in the comment
// from entry 64 (@40): expected store as dmem address then data, FFFFFFFF ends the list
12300093 // 00 addi x1, x0, 0x123
ABCDE137 // 04 lui x2, 0xabcde
FFB00193 // 08 addi x3, x0, -5
00308233 // 0c add x4, x1, x3
10402023 // 10 sw x4, 0x100(x0)
403082B3 // 14 sub x5, x1, x3
10502223 // 18 sw x5, 0x104(x0)
40415313 // 1c srai x6, x2, 4
10602423 // 20 sw x6, 0x108(x0)
00809393 // 24 slli x7, x1, 8
10702623 // 28 sw x7, 0x10c(x0)
00115433 // 2c srl x8, x2, x1
10802823 // 30 sw x8, 0x110(x0)
0011A4B3 // 34 slt x9, x3, x1
0011B533 // 38 sltu x10, x3, x1
00449493 // 3c slli x9, x9, 4
00A4E4B3 // 40 or x9, x9, x10
10902A23 // 44 sw x9, 0x114(x0)
001145B3 // 48 xor x11, x2, x1
7F05F593 // 4c andi x11, x11, 0x7f0
F005E593 // 50 ori x11, x11, -256
10B02C23 // 54 sw x11, 0x118(x0)
10202E23 // 58 sw x2, 0x11c(x0)
00001617 // 5c auipc x12, 0x1
12C02023 // 60 sw x12, 0x120(x0)
10002683 // 64 lw x13, 0x100(x0)
00168693 // 68 addi x13, x13, 1
12D02223 // 6c sw x13, 0x124(x0)
00108463 // 70 beq x1, x1, +8 taken
1E002E23 // 74 sw x0, 0x1fc(x0) wrong path
18102023 // 78 sw x1, 0x180(x0)
00109463 // 7c bne x1, x1, +8 not taken
18102223 // 80 sw x1, 0x184(x0)
0011C463 // 84 blt x3, x1, +8 taken
1E002E23 // 88 sw x0, 0x1fc(x0) wrong path
18102423 // 8c sw x1, 0x188(x0)
0011D463 // 90 bge x3, x1, +8 not taken
18102623 // 94 sw x1, 0x18c(x0)
0011E463 // 98 bltu x3, x1, +8 not taken
18102823 // 9c sw x1, 0x190(x0)
0011F463 // a0 bgeu x3, x1, +8 taken
1E002E23 // a4 sw x0, 0x1fc(x0) wrong path
18102A23 // a8 sw x1, 0x194(x0)
00800AEF // ac jal x21, +8
1E002E23 // b0 sw x0, 0x1fc(x0) wrong path
1B502023 // b4 sw x21, 0x1a0(x0)
0C400B13 // b8 addi x22, x0, 0xc4
001B0BE7 // bc jalr x23, 1(x22)
1E002E23 // c0 sw x0, 0x1fc(x0) wrong path
1B702223 // c4 sw x23, 0x1a4(x0)
C0202C73 // c8 csrr x24, instret
1B802823 // cc sw x24, 0x1b0(x0)
C0002CF3 // d0 csrr x25, cycle
1B902A23 // d4 sw x25, 0x1b4(x0)
C8002D73 // d8 csrr x26, cycleh
1BA02C23 // dc sw x26, 0x1b8(x0)
0000006F // e0 jal x0, 0
@40
00000100 0000011E // add
00000104 00000128 // sub
00000108 FABCDE00 // srai
0000010C 00012300 // slli
00000110 1579BC00 // srl by rs1[4:0] = 3
00000114 00000010 // slt and sltu
00000118 FFFFFF20 // xor, andi, ori
0000011C ABCDE000 // lui
00000120 0000105C // auipc
00000124 0000011F // lw of the first store plus one
00000180 00000123 // beq
00000184 00000123 // bne
00000188 00000123 // blt
0000018C 00000123 // bge
00000190 00000123 // bltu
00000194 00000123 // bgeu
000001A0 000000B0 // jal link
000001A4 000000C0 // jalr link
000001B0 0000002D // instret, 45 retired before the read
000001B4 000000D2 // cycle, read in cycle 210
000001B8 00000000 // cycleh
FFFFFFFF
